/* hdl/spi_boot_pkg.sv */
package spi_boot_pkg;

   //////////////////////////////////////////////////
   // Widths
   //////////////////////////////////////////////////
   localparam int addr_bits  = 24;        // Flash byte address
   localparam int byte_bits  = 8;
   localparam int word_bits  = 32;        // Boot word
   localparam int count_bits = 8;         // Words per transfer
   localparam int cmd_bits   = byte_bits + addr_bits;
   localparam int cmd_cnt_bits = $clog2(cmd_bits);   // Counts command cycles

   typedef logic [addr_bits-1:0]  flash_addr_t;
   typedef logic [byte_bits-1:0]  flash_byte_t;
   typedef logic [word_bits-1:0]  boot_word_t;
   typedef logic [count_bits-1:0] word_count_t;
   typedef logic [cmd_bits-1:0]   cmd_word_t;  // Command byte above address

   // Plain read, no dummy cycles
   localparam flash_byte_t read_cmd = 8'h03;

   //////////////////////////////////////////////////
   // Sequencer states
   //////////////////////////////////////////////////
   typedef enum logic [1:0] {
      seq_idle,   // Waiting for start
      seq_cmd,    // Command and address out
      seq_data,   // Words coming in
      seq_done    // One cycle for done
   } seq_state_t;

   // Word strobe toward the consumer
   typedef struct packed {
      logic        word_valid;   // One cycle per word
      boot_word_t  word_data;    // First byte in 7:0
      word_count_t word_index;   // 0 for first word
   } word_out_t;

endpackage

/* hdl/spi_bit_shifter.sv */
module spi_bit_shifter (
   input  logic                      SPI_SCK,
   input  logic                      rst_n,
   input  logic                      load,
   input  spi_boot_pkg::cmd_word_t   cmd_word,
   input  logic                      shift_en,
   input  logic                      spi_miso,
   output logic                      spi_mosi,
   output logic                      byte_valid,
   output spi_boot_pkg::flash_byte_t rx_byte
);
   import spi_boot_pkg::*;

   cmd_word_t   tx_sr;      // Outgoing bits, MSB first
   flash_byte_t rx_sr;      // Incoming bits
   logic [2:0]  bit_cnt;    // Position inside current byte

   //////////////////////////////////////////////////
   // Transmit side and byte framing
   //////////////////////////////////////////////////
   always_ff @(posedge SPI_SCK or negedge rst_n) begin
      if (!rst_n) begin
         tx_sr      <= '0;          // Keeps mosi low
         bit_cnt    <= '0;
         byte_valid <= 1'b0;
      end else if (load) begin
         tx_sr      <= cmd_word;    // Bit 31 on the wire right away
         bit_cnt    <= '0;
         byte_valid <= 1'b0;
      end else begin
         // Zeros follow the last address bit
         tx_sr      <= {tx_sr[cmd_bits-2:0], 1'b0};
         byte_valid <= shift_en && (bit_cnt == 3'd7);   // 8th bit this edge
         if (shift_en) begin
            bit_cnt <= bit_cnt + 3'd1;   // Wraps at byte boundary
         end
      end
   end

   //////////////////////////////////////////////////
   // Receive side
   //////////////////////////////////////////////////
   always_ff @(posedge SPI_SCK) begin
      if (shift_en) begin
         rx_sr <= {rx_sr[byte_bits-2:0], spi_miso};   // MSB arrives first
      end
   end

   // Whole byte sits in rx_sr while byte_valid is high
   assign rx_byte  = rx_sr;
   assign spi_mosi = tx_sr[cmd_bits-1];

endmodule

/* hdl/flash_read_sequencer.sv */
module flash_read_sequencer (
   input  logic                      SPI_SCK,
   input  logic                      rst_n,
   input  logic                      start,        // One-cycle pulse
   input  spi_boot_pkg::flash_addr_t start_addr,
   input  spi_boot_pkg::word_count_t word_count,
   input  logic                      word_valid,   // From the packer
   output logic                      load,
   output spi_boot_pkg::cmd_word_t   cmd_word,
   output logic                      shift_en,
   output logic                      clear,
   output logic                      spi_cs_l,
   output logic                      busy,
   output logic                      done
);
   import spi_boot_pkg::*;

   seq_state_t              state;
   logic [cmd_cnt_bits-1:0] cmd_cnt;       // Command cycles sent
   word_count_t             words_total;   // Captured at start
   word_count_t             words_rx;      // Words seen so far
   logic                    accept;
   logic                    last_word;

   //////////////////////////////////////////////////
   // Start acceptance
   //////////////////////////////////////////////////
   // Only from idle, so starts while busy fall away
   assign accept = (state == seq_idle) && start;

   // Shifter and packer both restart on the accepted start
   assign load  = accept;
   assign clear = accept;

   // Read opcode then 24-bit address
   assign cmd_word = {read_cmd, start_addr};

   // Sample miso for the whole data phase
   assign shift_en = (state == seq_data);

   assign last_word = word_valid && (words_rx == words_total - 8'd1);

   //////////////////////////////////////////////////
   // FSM
   //////////////////////////////////////////////////
   always_ff @(posedge SPI_SCK or negedge rst_n) begin
      if (!rst_n) begin
         state       <= seq_idle;
         cmd_cnt     <= '0;
         words_total <= '0;
         words_rx    <= '0;
         spi_cs_l    <= 1'b1;    // Flash deselected
         busy        <= 1'b0;
         done        <= 1'b0;
      end else begin
         done <= 1'b0;           // Pulse by default
         case (state)
            seq_idle: begin
               if (accept) begin
                  state    <= seq_cmd;
                  cmd_cnt  <= '0;
                  words_rx <= '0;
                  spi_cs_l <= 1'b0;   // Select with first command bit
                  busy     <= 1'b1;
                  // Zero means a single word
                  if (word_count == '0) begin
                     words_total <= 8'd1;
                  end else begin
                     words_total <= word_count;
                  end
               end
            end

            seq_cmd: begin
               cmd_cnt <= cmd_cnt + 1'b1;
               // Flash takes bit 0 at this edge
               if (cmd_cnt == cmd_cnt_bits'(cmd_bits - 1)) begin
                  state <= seq_data;
               end
            end

            seq_data: begin
               if (word_valid) begin
                  words_rx <= words_rx + 8'd1;
               end
               if (last_word) begin
                  state    <= seq_done;
                  spi_cs_l <= 1'b1;   // End of burst
                  busy     <= 1'b0;
                  done     <= 1'b1;
               end
            end

            seq_done: begin
               state <= seq_idle;     // done drops here
            end

            default: begin
               state <= seq_idle;
            end
         endcase
      end
   end

endmodule

/* hdl/word_packer.sv */
module word_packer (
   input  logic                      SPI_SCK,
   input  logic                      rst_n,
   input  logic                      clear,        // New transfer
   input  logic                      byte_valid,
   input  spi_boot_pkg::flash_byte_t rx_byte,
   output spi_boot_pkg::word_out_t   word_out
);
   import spi_boot_pkg::*;

   logic [1:0]  lane;            // Lane 0 holds bits 7:0
   logic [word_bits-byte_bits-1:0] acc;   // Lanes 0 to 2 collect here
   logic        word_valid_q;
   boot_word_t  word_data_q;
   word_count_t word_index_q;
   word_count_t next_index;

   //////////////////////////////////////////////////
   // Lane and index control
   //////////////////////////////////////////////////
   always_ff @(posedge SPI_SCK or negedge rst_n) begin
      if (!rst_n) begin
         lane         <= '0;
         word_valid_q <= 1'b0;
         word_index_q <= '0;
         next_index   <= '0;
      end else if (clear) begin
         lane         <= '0;
         word_valid_q <= 1'b0;
         next_index   <= '0;     // First word gets index 0
      end else begin
         word_valid_q <= byte_valid && (lane == 2'd3);   // Fourth byte in
         if (byte_valid) begin
            lane <= lane + 2'd1;
            if (lane == 2'd3) begin
               word_index_q <= next_index;
               next_index   <= next_index + 8'd1;
            end
         end
      end
   end

   // Little-endian assembly
   always_ff @(posedge SPI_SCK) begin
      if (byte_valid) begin
         if (lane == 2'd3) begin
            word_data_q <= {rx_byte, acc};   // Last byte on top
         end else begin
            acc[lane*byte_bits +: byte_bits] <= rx_byte;
         end
      end
   end

   assign word_out = '{word_valid: word_valid_q,
                       word_data:  word_data_q,
                       word_index: word_index_q};

endmodule

/* hdl/activity_led.sv */
module activity_led #(
   parameter int led_div_bits = 5    // Blink divider width
) (
   input  logic       SPI_SCK,
   input  logic       rst_n,
   input  logic       spi_cs_l,
   output logic [1:0] led_inc
);

   logic [led_div_bits-1:0] blink_cnt;

   //////////////////////////////////////////////////
   // Blink counter and LEDs
   //////////////////////////////////////////////////
   always_ff @(posedge SPI_SCK or negedge rst_n) begin
      if (!rst_n) begin
         blink_cnt <= '0;
         led_inc   <= '0;
      end else begin
         // Frozen while the flash is selected
         if (spi_cs_l) begin
            blink_cnt <= blink_cnt + 1'b1;
         end
         led_inc[1] <= blink_cnt[led_div_bits-1] & spi_cs_l;   // Idle blink
         led_inc[0] <= ~spi_cs_l;                              // Bus active
      end
   end

endmodule

/* hdl/spi_boot_top.sv */
module spi_boot_top #(
   parameter int led_div_bits = 5
) (
   input  logic                      SPI_SCK,
   input  logic                      pll_locked,   // Async reset, low active
   input  logic                      spi_miso,
   input  logic                      start,
   input  spi_boot_pkg::flash_addr_t start_addr,
   input  spi_boot_pkg::word_count_t word_count,
   output logic                      spi_cs_l,
   output logic                      spi_mosi,
   output spi_boot_pkg::word_out_t   word_out,
   output logic                      busy,
   output logic                      done,
   output logic [1:0]                led_inc
);
   import spi_boot_pkg::*;

   logic [1:0]  rst_sync;
   logic        rst_n;
   logic        load;
   cmd_word_t   cmd_word;
   logic        shift_en;
   logic        clear;
   logic        byte_valid;
   flash_byte_t rx_byte;

   //////////////////////////////////////////////////
   // Reset synchronizer
   //////////////////////////////////////////////////
   // Drops at once with pll_locked, releases two edges later
   always_ff @(posedge SPI_SCK or negedge pll_locked) begin
      if (!pll_locked) begin
         rst_sync <= '0;
      end else begin
         rst_sync <= {rst_sync[0], 1'b1};
      end
   end

   assign rst_n = rst_sync[1];

   //////////////////////////////////////////////////
   // Datapath
   //////////////////////////////////////////////////
   flash_read_sequencer i_flash_read_sequencer (
      .SPI_SCK    (SPI_SCK),
      .rst_n      (rst_n),
      .start      (start),
      .start_addr (start_addr),
      .word_count (word_count),
      .word_valid (word_out.word_valid),   // Counted toward word_count
      .load       (load),
      .cmd_word   (cmd_word),
      .shift_en   (shift_en),
      .clear      (clear),
      .spi_cs_l   (spi_cs_l),
      .busy       (busy),
      .done       (done)
   );

   spi_bit_shifter i_spi_bit_shifter (
      .SPI_SCK    (SPI_SCK),
      .rst_n      (rst_n),
      .load       (load),
      .cmd_word   (cmd_word),
      .shift_en   (shift_en),
      .spi_miso   (spi_miso),
      .spi_mosi   (spi_mosi),
      .byte_valid (byte_valid),
      .rx_byte    (rx_byte)
   );

   word_packer i_word_packer (
      .SPI_SCK    (SPI_SCK),
      .rst_n      (rst_n),
      .clear      (clear),
      .byte_valid (byte_valid),
      .rx_byte    (rx_byte),
      .word_out   (word_out)
   );

   // Board LEDs
   activity_led #(
      .led_div_bits (led_div_bits)
   ) i_activity_led (
      .SPI_SCK  (SPI_SCK),
      .rst_n    (rst_n),
      .spi_cs_l (spi_cs_l),
      .led_inc  (led_inc)
   );

endmodule

/* sim/flash_model.sv */
module flash_model (
   input  logic                    SPI_SCK,
   input  logic                    spi_cs_l,
   input  logic                    spi_mosi,
   output logic                    spi_miso,
   output logic                    cmd_strobe,     // One cycle after 32nd command bit
   output spi_boot_pkg::cmd_word_t cmd_captured
);
   import spi_boot_pkg::*;

   cmd_word_t   cmd_sr;
   int          cmd_cnt = 0;          // Command bits taken so far
   logic        data_phase = 1'b0;    // Read decoded, data going out
   flash_addr_t rd_addr = '0;
   logic [2:0]  bit_pos = 3'd7;       // Bit of cur_byte on miso
   flash_byte_t cur_byte;

   initial cmd_strobe = 1'b0;

   // Content pattern, a function of the whole address
   function automatic flash_byte_t byte_at(input flash_addr_t a);
      return a[7:0] ^ a[15:8] ^ a[23:16] ^ 8'h5a;
   endfunction

   //////////////////////////////////////////////////
   // Command decode and data stream
   //////////////////////////////////////////////////
   always @(posedge SPI_SCK) begin
      cmd_strobe <= 1'b0;
      if (spi_cs_l) begin
         cmd_cnt    <= 0;                 // Deselect ends any read
         data_phase <= 1'b0;
      end else if (cmd_cnt < 32) begin
         cmd_sr  <= {cmd_sr[30:0], spi_mosi};   // MSB first
         cmd_cnt <= cmd_cnt + 1;
         if (cmd_cnt == 31) begin
            cmd_captured <= {cmd_sr[30:0], spi_mosi};
            cmd_strobe   <= 1'b1;
            rd_addr      <= {cmd_sr[22:0], spi_mosi};
            data_phase   <= (cmd_sr[30:23] == 8'h03);   // Plain read only
            bit_pos      <= 3'd7;
         end
      end else if (data_phase) begin
         if (bit_pos == 3'd0) begin
            rd_addr <= rd_addr + 1'b1;   // Next byte, wraps at top
         end
         bit_pos <= bit_pos - 3'd1;       // 0 wraps to 7
      end
   end

   // Changes just after the edge, sampled on the next one
   assign cur_byte = byte_at(rd_addr);
   assign spi_miso = data_phase & cur_byte[bit_pos];

endmodule

/* sim/tb_spi_boot.sv */
module tb_spi_boot;
   import spi_boot_pkg::*;

   localparam int          drive_dly    = 10;      // Input skew after rising edge
   localparam int          led_div      = 5;
   localparam flash_byte_t exp_read_cmd = 8'h03;

   logic        SPI_SCK;
   logic        pll_locked;
   logic        spi_miso;
   logic        start;
   flash_addr_t start_addr;
   word_count_t word_count;
   logic        spi_cs_l;
   logic        spi_mosi;
   word_out_t   word_out;
   logic        busy;
   logic        done;
   logic [1:0]  led_inc;
   logic        cmd_strobe;
   cmd_word_t   cmd_captured;

   logic [31:0] lfsr;
   flash_addr_t exp_addr;       // Running transfer
   word_count_t exp_count;
   int          words_seen;
   int          cmd_seen;
   logic        done_seen;
   logic        expect_words;   // Strobes allowed now
   logic        exp_busy;       // Accepted start up to done
   logic        led_chk_en;
   logic        prev_valid;
   logic        prev_cs;        // spi_cs_l one cycle back
   logic        prev_led1;
   int          led_toggles;

   spi_boot_top #(.led_div_bits(led_div)) i_spi_boot_top (
      .SPI_SCK    (SPI_SCK),
      .pll_locked (pll_locked),
      .spi_miso   (spi_miso),
      .start      (start),
      .start_addr (start_addr),
      .word_count (word_count),
      .spi_cs_l   (spi_cs_l),
      .spi_mosi   (spi_mosi),
      .word_out   (word_out),
      .busy       (busy),
      .done       (done),
      .led_inc    (led_inc)
   );

   flash_model i_flash_model (
      .SPI_SCK      (SPI_SCK),
      .spi_cs_l     (spi_cs_l),
      .spi_mosi     (spi_mosi),
      .spi_miso     (spi_miso),
      .cmd_strobe   (cmd_strobe),
      .cmd_captured (cmd_captured)
   );

   always #50 SPI_SCK = ~SPI_SCK;

   //////////////////////////////////////////////////
   // Random source and reference model
   //////////////////////////////////////////////////
   // Fibonacci taps 32 22 2 1 stepped once per bit
   function automatic logic [31:0] random_bits(input int n);
      logic [31:0] v;
      logic        fb;
      v = '0;
      for (int i = 0; i < n; i++) begin
         fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
         lfsr = {lfsr[30:0], fb};
         v    = {v[30:0], fb};
      end
      return v;
   endfunction

   function automatic flash_byte_t expected_byte(input flash_addr_t a);
      return a[7:0] ^ a[15:8] ^ a[23:16] ^ 8'h5a;
   endfunction

   // Word n of a read with its first byte in 7:0
   function automatic boot_word_t expected_word(input flash_addr_t base, input int n);
      flash_addr_t a;
      boot_word_t  w;
      a = base + flash_addr_t'(4 * n);
      for (int k = 0; k < 4; k++) begin
         w[8*k +: 8] = expected_byte(a + flash_addr_t'(k));
      end
      return w;
   endfunction

   //////////////////////////////////////////////////
   // Checks
   //////////////////////////////////////////////////
   task automatic stop_on_error(input string why);
      $display("%s", why);
      $display("Simulation FAILED");
      $fatal(1);
   endtask

   task automatic check_word(input string name, input boot_word_t got, input boot_word_t exp);
      if (got !== exp) stop_on_error($sformatf("Mismatch %s: got 0x%h, expected 0x%h",
                                               name, got, exp));
   endtask

   task automatic check_index(input string name, input word_count_t got,
                              input word_count_t exp);
      if (got !== exp) stop_on_error($sformatf("Mismatch %s: got 0x%h, expected 0x%h",
                                               name, got, exp));
   endtask

   task automatic check_cmd(input string name, input cmd_word_t got, input cmd_word_t exp);
      if (got !== exp) stop_on_error($sformatf("Mismatch %s: got 0x%h, expected 0x%h",
                                               name, got, exp));
   endtask

   task automatic check_level(input string name, input logic got, input logic exp);
      if (got !== exp) stop_on_error($sformatf("Mismatch %s: got 0x%h, expected 0x%h",
                                               name, got, exp));
   endtask

   // Mid-cycle monitor of the DUT outputs
   always @(negedge SPI_SCK) begin
      if (cmd_strobe) begin
         if (!expect_words) stop_on_error("flash got a command with no transfer running");
         check_cmd("flash command", cmd_captured, {exp_read_cmd, exp_addr});
         cmd_seen++;
      end
      if (word_out.word_valid) begin
         if (!expect_words) stop_on_error("word strobe with no transfer running");
         if (words_seen >= exp_count) stop_on_error("more words than requested");
         check_index("word_index", word_out.word_index, word_count_t'(words_seen));
         check_word("word_data", word_out.word_data, expected_word(exp_addr, words_seen));
         words_seen++;
      end
      if (done) begin
         if (!expect_words) stop_on_error("done pulse with no transfer running");
         check_index("words before done", word_count_t'(words_seen), exp_count);
         done_seen    = 1'b1;
         expect_words = 1'b0;   // Transfer closed
         exp_busy     = 1'b0;   // Bus released with done
      end
      if (led_chk_en) begin
         check_level("busy", busy, exp_busy);
         check_level("spi_cs_l", spi_cs_l, ~exp_busy);
         if (spi_cs_l) check_level("spi_mosi", spi_mosi, 1'b0);
         if (prev_valid) begin
            check_level("led_inc[0]", led_inc[0], ~prev_cs);
            if (!prev_cs) check_level("led_inc[1]", led_inc[1], 1'b0);
            if (led_inc[1] !== prev_led1) led_toggles++;
         end
         prev_cs    = spi_cs_l;
         prev_led1  = led_inc[1];
         prev_valid = 1'b1;
      end else begin
         prev_valid = 1'b0;
      end
   end

   //////////////////////////////////////////////////
   // Stimulus tasks
   //////////////////////////////////////////////////
   task automatic hold_reset(input int cycles);
      led_chk_en = 1'b0;
      pll_locked = 1'b0;
      repeat (cycles) @(posedge SPI_SCK);
      #drive_dly;
      check_level("spi_cs_l in reset", spi_cs_l, 1'b1);
      check_level("busy in reset", busy, 1'b0);
      check_level("done in reset", done, 1'b0);
      check_level("word_valid in reset", word_out.word_valid, 1'b0);
      check_level("spi_mosi in reset", spi_mosi, 1'b0);
      check_level("led_inc[1] in reset", led_inc[1], 1'b0);
      check_level("led_inc[0] in reset", led_inc[0], 1'b0);
      pll_locked = 1'b1;
      repeat (4) @(posedge SPI_SCK);    // Two synchronizer flops plus margin
      #drive_dly;
      led_chk_en = 1'b1;
   endtask

   task automatic begin_transfer(input flash_addr_t addr, input word_count_t count);
      logic [31:0] r;
      exp_addr   = addr;
      exp_count  = (count == 8'd0) ? 8'd1 : count;   // Zero reads one word
      words_seen = 0;
      cmd_seen   = 0;
      done_seen  = 1'b0;
      @(posedge SPI_SCK);
      #drive_dly;
      check_level("busy before start", busy, 1'b0);
      expect_words = 1'b1;
      start        = 1'b1;
      start_addr   = addr;
      word_count   = count;
      @(posedge SPI_SCK);
      #drive_dly;
      start    = 1'b0;
      exp_busy = 1'b1;
      check_level("spi_cs_l after start", spi_cs_l, 1'b0);
      check_level("busy after start", busy, 1'b1);
      r          = random_bits(32);
      start_addr = r[23:0];      // Captured values must hold
      word_count = r[31:24];
   endtask

   task automatic run_transfer(input flash_addr_t addr, input word_count_t count,
                               input logic extra_starts);
      logic [31:0] r;
      int          limit;
      int          cyc;
      begin_transfer(addr, count);
      limit = 32 * (exp_count + 2);
      cyc   = 0;
      while (!done_seen && cyc < limit) begin
         @(posedge SPI_SCK);
         #drive_dly;
         start = 1'b0;
         if (extra_starts && busy) begin
            r = random_bits(2);
            if (r[1:0] == 2'b00) begin
               start      = 1'b1;            // Must be ignored
               r          = random_bits(24);
               start_addr = r[23:0];
            end
         end
         cyc++;
      end
      start = 1'b0;
      if (!done_seen) stop_on_error("timeout waiting for done");
      if (cmd_seen != 1) stop_on_error("flash did not see exactly one command");
      check_level("spi_cs_l after done", spi_cs_l, 1'b1);
      check_level("busy after done", busy, 1'b0);
      repeat (4) @(posedge SPI_SCK);   // Quiet time for late words
   endtask

   // pll_locked drop in the middle of an 8-word read
   task automatic abort_with_reset(input flash_addr_t addr, input int cut);
      begin_transfer(addr, 8'd8);
      repeat (cut) @(posedge SPI_SCK);
      #drive_dly;
      if (done_seen) stop_on_error("transfer ended before the reset drop");
      expect_words = 1'b0;
      exp_busy     = 1'b0;
      led_chk_en   = 1'b0;
      pll_locked   = 1'b0;
      #1;
      check_level("spi_cs_l at reset drop", spi_cs_l, 1'b1);
      check_level("busy at reset drop", busy, 1'b0);
      hold_reset(3);
   endtask

   //////////////////////////////////////////////////
   // Test sequence
   //////////////////////////////////////////////////
   initial begin
      int          blink0;
      flash_addr_t addr;
      word_count_t cnt;
      SPI_SCK      = 1'b0;
      pll_locked   = 1'b0;
      start        = 1'b0;
      start_addr   = '0;
      word_count   = '0;
      lfsr         = 32'ha3efeb7b;
      expect_words = 1'b0;
      exp_busy     = 1'b0;
      led_chk_en   = 1'b0;
      prev_valid   = 1'b0;
      done_seen    = 1'b0;
      led_toggles  = 0;
      exp_count    = '0;
      hold_reset(10);

      // Blink LED moves in a long idle stretch
      blink0 = led_toggles;
      repeat (200) @(posedge SPI_SCK);
      if (led_toggles - blink0 < 4) stop_on_error("led_inc[1] did not blink while idle");

      for (int t = 0; t < 12; t++) begin
         repeat (1 + random_bits(4)) @(posedge SPI_SCK);   // Idle gap
         addr = flash_addr_t'(random_bits(24));
         cnt  = word_count_t'(random_bits(3)) + 8'd1;
         run_transfer(addr, cnt, t[0]);
      end
      run_transfer(24'hfffff8, 8'd4, 1'b1);     // Address wraps
      run_transfer(flash_addr_t'(random_bits(24)), 8'd0, 1'b0);

      abort_with_reset(flash_addr_t'(random_bits(24)), 40 + int'(random_bits(7)));
      run_transfer(flash_addr_t'(random_bits(24)), 8'd3, 1'b1); // Works again after abort

      $display("Simulation PASSED");
      $finish;
   end

endmodule

/* spi_boot.f */
hdl/spi_boot_pkg.sv
hdl/spi_bit_shifter.sv
hdl/flash_read_sequencer.sv
hdl/word_packer.sv
hdl/activity_led.sv
hdl/spi_boot_top.sv
sim/flash_model.sv
sim/tb_spi_boot.sv
